/* logic/stream_pkg.sv */
// ========================================
// Stream package
// Byte-wide payload beat shared by every
// payload stream in the echo path
// ========================================

package stream_pkg;

    // Width of one payload byte
    localparam int BYTE_W = 8;

    // One payload beat, 10 bits in total
    typedef struct packed {
        // Payload byte
        logic [BYTE_W-1:0] data;
        // Final byte of a datagram
        logic              last;
        // Upstream error flag, carried along with the byte
        logic              user;
    } payload_beat_t;

endpackage

/* logic/udp_pkg.sv */
// ========================================
// UDP package
// Datagram header layout, reply constants
// and default local addressing
// ========================================

package udp_pkg;

    // Field widths
    localparam int IP_ADDR_W = 32;
    localparam int PORT_W    = 16;
    localparam int TTL_W     = 8;

    // Parsed UDP header, 136 bits
    // Same layout for inbound and reply headers
    typedef struct packed {
        logic [IP_ADDR_W-1:0] source_ip;
        logic [IP_ADDR_W-1:0] dest_ip;
        logic [PORT_W-1:0]    source_port;
        logic [PORT_W-1:0]    dest_port;
        // UDP length field, copied into the reply
        logic [PORT_W-1:0]    length;
        logic [PORT_W-1:0]    checksum;
        logic [TTL_W-1:0]     ttl;
    } udp_hdr_t;

    // Time-to-live of every reply
    localparam logic [TTL_W-1:0] REPLY_TTL = 8'd64;

    // Zero checksum means none was computed
    localparam logic [PORT_W-1:0] REPLY_CHECKSUM = 16'd0;

    // Port the echo service answers on
    localparam logic [PORT_W-1:0] DEFAULT_LISTEN_PORT = 16'd1234;

    // 172.28.0.6
    localparam logic [IP_ADDR_W-1:0] DEFAULT_LOCAL_IP = {8'd172, 8'd28, 8'd0, 8'd6};

endpackage

/* logic/stream_fifo.sv */
// ========================================
// Stream FIFO
// Show-ahead synchronous FIFO with a
// valid/ready stream on each side
// ========================================

`timescale 1ns/1ps

module stream_fifo #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  item_t in_item,
    input  logic  in_valid,
    output logic  in_ready,
    output item_t out_item,
    output logic  out_valid,
    input  logic  out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    item_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    assign in_ready  = (count != FULL_CNT);
    assign out_valid = (count != '0);

    // Head of the queue is always visible
    assign out_item = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_item;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* logic/datagram_filter.sv */
// ========================================
// Datagram filter
// Matches the destination port, builds the
// reply header and steers or drops payload
// ========================================

`timescale 1ns/1ps

module datagram_filter #(
    parameter logic [15:0] LISTEN_PORT = 16'd1234,
    parameter logic [31:0] LOCAL_IP    = 32'hac1c_0006
) (
    input  logic                    clk,
    input  logic                    rst,

    input  udp_pkg::udp_hdr_t       rx_hdr,
    input  logic                    rx_hdr_valid,
    output logic                    rx_hdr_ready,

    input  stream_pkg::payload_beat_t rx_payload,
    input  logic                    rx_payload_valid,
    output logic                    rx_payload_ready,

    output udp_pkg::udp_hdr_t       reply_hdr,
    output logic                    reply_hdr_valid,
    input  logic                    reply_hdr_ready,

    output stream_pkg::payload_beat_t fwd_payload,
    output logic                    fwd_payload_valid,
    input  logic                    fwd_payload_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FORWARD,
        ST_DISCARD
    } state_t;

    state_t state;

    logic port_match;
    logic hdr_fire;
    logic payload_fire;

    assign port_match = (rx_hdr.dest_port == LISTEN_PORT);

    // Headers move only between datagrams and while a reply slot is free
    assign rx_hdr_ready = (state == ST_IDLE) && reply_hdr_ready;
    assign hdr_fire     = rx_hdr_valid && rx_hdr_ready;

    // Reply goes out in the same cycle the inbound header is taken
    assign reply_hdr_valid = (state == ST_IDLE) && rx_hdr_valid && port_match;

    always_comb begin
        reply_hdr.source_ip   = LOCAL_IP;
        reply_hdr.dest_ip     = rx_hdr.source_ip;
        // Answer from the port that was addressed
        reply_hdr.source_port = rx_hdr.dest_port;
        reply_hdr.dest_port   = rx_hdr.source_port;
        reply_hdr.length      = rx_hdr.length;
        reply_hdr.ttl         = udp_pkg::REPLY_TTL;
        reply_hdr.checksum    = udp_pkg::REPLY_CHECKSUM;
    end

    // Payload passes on unchanged while forwarding
    assign fwd_payload       = rx_payload;
    assign fwd_payload_valid = (state == ST_FORWARD) && rx_payload_valid;

    always_comb begin
        case (state)
            ST_FORWARD: rx_payload_ready = fwd_payload_ready;
            // Swallow everything up to the last byte
            ST_DISCARD: rx_payload_ready = 1'b1;
            default:    rx_payload_ready = 1'b0;
        endcase
    end

    assign payload_fire = rx_payload_valid && rx_payload_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_fire) begin
                        state <= port_match ? ST_FORWARD : ST_DISCARD;
                    end
                end
                ST_FORWARD, ST_DISCARD: begin
                    if (payload_fire && rx_payload.last) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* logic/led_capture.sv */
// ========================================
// LED capture
// Shows the first byte of each outgoing
// datagram on the LEDs
// ========================================

`timescale 1ns/1ps

module led_capture (
    input  logic                          clk,
    input  logic                          rst,
    input  stream_pkg::payload_beat_t     beat,
    input  logic                          beat_fire,
    output logic [stream_pkg::BYTE_W-1:0] leds
);

    // Next transfer opens a new datagram
    logic at_start;

    always_ff @(posedge clk) begin
        if (rst) begin
            at_start <= 1'b1;
            leds     <= '0;
        end else if (beat_fire) begin
            if (at_start) begin
                leds <= beat.data;
            end
            at_start <= beat.last;
        end
    end

endmodule

/* logic/udp_echo_top.sv */
// ========================================
// UDP echo top level
// Filter, header queue, payload FIFO and
// LED capture at the UDP stream boundary
// ========================================

`timescale 1ns/1ps

module udp_echo_top #(
    parameter logic [15:0] LISTEN_PORT   = udp_pkg::DEFAULT_LISTEN_PORT,
    parameter logic [31:0] LOCAL_IP      = udp_pkg::DEFAULT_LOCAL_IP,
    parameter int          PAYLOAD_DEPTH = 2048,
    parameter int          HDR_DEPTH     = 4
) (
    input  logic                          clk,
    input  logic                          rst,

    // Inbound datagram
    input  udp_pkg::udp_hdr_t             rx_hdr,
    input  logic                          rx_hdr_valid,
    output logic                          rx_hdr_ready,
    input  stream_pkg::payload_beat_t     rx_payload,
    input  logic                          rx_payload_valid,
    output logic                          rx_payload_ready,

    // Echoed datagram
    output udp_pkg::udp_hdr_t             tx_hdr,
    output logic                          tx_hdr_valid,
    input  logic                          tx_hdr_ready,
    output stream_pkg::payload_beat_t     tx_payload,
    output logic                          tx_payload_valid,
    input  logic                          tx_payload_ready,

    output logic [stream_pkg::BYTE_W-1:0] leds
);

    udp_pkg::udp_hdr_t         reply_hdr;
    logic                      reply_hdr_valid;
    logic                      reply_hdr_ready;

    stream_pkg::payload_beat_t fwd_payload;
    logic                      fwd_payload_valid;
    logic                      fwd_payload_ready;

    logic                      tx_payload_fire;

    datagram_filter #(
        .LISTEN_PORT(LISTEN_PORT),
        .LOCAL_IP   (LOCAL_IP)
    ) datagram_filter_inst (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .reply_hdr        (reply_hdr),
        .reply_hdr_valid  (reply_hdr_valid),
        .reply_hdr_ready  (reply_hdr_ready),
        .fwd_payload      (fwd_payload),
        .fwd_payload_valid(fwd_payload_valid),
        .fwd_payload_ready(fwd_payload_ready)
    );

    // Lets several replies wait while payload drains
    stream_fifo #(
        .item_t(udp_pkg::udp_hdr_t),
        .DEPTH (HDR_DEPTH)
    ) hdr_queue (
        .clk      (clk),
        .rst      (rst),
        .in_item  (reply_hdr),
        .in_valid (reply_hdr_valid),
        .in_ready (reply_hdr_ready),
        .out_item (tx_hdr),
        .out_valid(tx_hdr_valid),
        .out_ready(tx_hdr_ready)
    );

    stream_fifo #(
        .item_t(stream_pkg::payload_beat_t),
        .DEPTH (PAYLOAD_DEPTH)
    ) payload_fifo (
        .clk      (clk),
        .rst      (rst),
        .in_item  (fwd_payload),
        .in_valid (fwd_payload_valid),
        .in_ready (fwd_payload_ready),
        .out_item (tx_payload),
        .out_valid(tx_payload_valid),
        .out_ready(tx_payload_ready)
    );

    assign tx_payload_fire = tx_payload_valid && tx_payload_ready;

    led_capture led_capture_inst (
        .clk      (clk),
        .rst      (rst),
        .beat     (tx_payload),
        .beat_fire(tx_payload_fire),
        .leds     (leds)
    );

endmodule

/* tb/tb_udp_echo.sv */
// ========================================
// UDP echo testbench
// Directed tests for echo, discard,
// back-pressure and the LED byte
// ========================================

`timescale 1ns/1ps

module tb_udp_echo;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 16;
    // Small enough that three 20-byte datagrams fill it
    localparam int PAYLOAD_DEPTH = 32;
    localparam int HDR_DEPTH     = 4;
    localparam int IDLE_LIMIT    = 100;
    // About 100 beats plus headers stay well under 1000 cycles with stalls
    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [7:0]  EXPECTED_TTL = 8'd64;
    localparam logic [15:0] OTHER_PORT   = udp_pkg::DEFAULT_LISTEN_PORT + 16'd1;

    typedef stream_pkg::payload_beat_t beat_q_t[$];

    logic                      clk;
    logic                      rst;
    udp_pkg::udp_hdr_t         rx_hdr;
    logic                      rx_hdr_valid;
    logic                      rx_hdr_ready;
    stream_pkg::payload_beat_t rx_payload;
    logic                      rx_payload_valid;
    logic                      rx_payload_ready;
    udp_pkg::udp_hdr_t         tx_hdr;
    logic                      tx_hdr_valid;
    logic                      tx_hdr_ready;
    stream_pkg::payload_beat_t tx_payload;
    logic                      tx_payload_valid;
    logic                      tx_payload_ready;
    logic [7:0]                leds;

    logic [15:0]       lfsr_state;
    int                checks;
    int                errors;
    int                cycle_count;
    int                payload_stalls;
    udp_pkg::udp_hdr_t got_hdrs[$];
    beat_q_t           got_beats;

    udp_echo_top #(
        .LISTEN_PORT  (udp_pkg::DEFAULT_LISTEN_PORT),
        .LOCAL_IP     (udp_pkg::DEFAULT_LOCAL_IP),
        .PAYLOAD_DEPTH(PAYLOAD_DEPTH),
        .HDR_DEPTH    (HDR_DEPTH)
    ) udp_echo_top_inst (
        .clk             (clk),
        .rst             (rst),
        .rx_hdr          (rx_hdr),
        .rx_hdr_valid    (rx_hdr_valid),
        .rx_hdr_ready    (rx_hdr_ready),
        .rx_payload      (rx_payload),
        .rx_payload_valid(rx_payload_valid),
        .rx_payload_ready(rx_payload_ready),
        .tx_hdr          (tx_hdr),
        .tx_hdr_valid    (tx_hdr_valid),
        .tx_hdr_ready    (tx_hdr_ready),
        .tx_payload      (tx_payload),
        .tx_payload_valid(tx_payload_valid),
        .tx_payload_ready(tx_payload_ready),
        .leds            (leds)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped: no finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic udp_pkg::udp_hdr_t make_header(input logic [15:0] port, input int n);
        udp_pkg::udp_hdr_t h;
        h.source_ip   = random_bits(32);
        h.dest_ip     = udp_pkg::DEFAULT_LOCAL_IP;
        h.source_port = 16'(random_bits(16));
        h.dest_port   = port;
        h.length      = 16'(n + 8);
        h.checksum    = 16'(random_bits(16));
        h.ttl         = 8'(random_bits(8));
        return h;
    endfunction

    function automatic beat_q_t make_payload(input int n, input int user_idx);
        beat_q_t                   q;
        stream_pkg::payload_beat_t b;
        int                        i;
        for (i = 0; i < n; i++) begin
            b.data = 8'(random_bits(8));
            b.last = (i == n - 1);
            b.user = (i == user_idx);
            q.push_back(b);
        end
        return q;
    endfunction

    // Local IP to sender with ports swapped, fixed TTL and no checksum
    function automatic udp_pkg::udp_hdr_t expected_reply(input udp_pkg::udp_hdr_t h);
        udp_pkg::udp_hdr_t r;
        r.source_ip   = udp_pkg::DEFAULT_LOCAL_IP;
        r.dest_ip     = h.source_ip;
        r.source_port = h.dest_port;
        r.dest_port   = h.source_port;
        r.length      = h.length;
        r.checksum    = 16'h0000;
        r.ttl         = EXPECTED_TTL;
        return r;
    endfunction

    task automatic check_value(input string name, input logic [135:0] got,
                               input logic [135:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Failure: %s", msg);
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d error(s)", name, errors - errors_before);
        end
    endtask

    task automatic send_datagram(input udp_pkg::udp_hdr_t hdr, input beat_q_t beats);
        int i;
        @(negedge clk);
        rx_hdr       = hdr;
        rx_hdr_valid = 1'b1;
        while (!rx_hdr_ready) @(negedge clk);
        // Header moved on the rising edge in between
        @(negedge clk);
        rx_hdr_valid = 1'b0;
        for (i = 0; i < beats.size(); i++) begin
            rx_payload       = beats[i];
            rx_payload_valid = 1'b1;
            while (!rx_payload_ready) begin
                payload_stalls++;
                @(negedge clk);
            end
            @(negedge clk);
        end
        rx_payload_valid = 1'b0;
    endtask

    task automatic collect_headers(input int count);
        int idle;
        idle = 0;
        while (got_hdrs.size() < count && idle < IDLE_LIMIT) begin
            @(negedge clk);
            tx_hdr_ready = 1'b1;
            if (tx_hdr_valid) begin
                got_hdrs.push_back(tx_hdr);
                idle = 0;
            end else begin
                idle++;
            end
        end
        @(negedge clk);
        tx_hdr_ready = 1'b0;
        if (got_hdrs.size() < count) begin
            report_failure($sformatf("only %0d of %0d reply headers appeared",
                                     got_hdrs.size(), count));
        end
    endtask

    task automatic collect_payload(input int count);
        int idle;
        idle = 0;
        while (got_beats.size() < count && idle < IDLE_LIMIT) begin
            @(negedge clk);
            tx_payload_ready = 1'b1;
            if (tx_payload_valid) begin
                got_beats.push_back(tx_payload);
                idle = 0;
            end else begin
                idle++;
            end
        end
        @(negedge clk);
        tx_payload_ready = 1'b0;
        if (got_beats.size() < count) begin
            report_failure($sformatf("only %0d of %0d payload bytes appeared",
                                     got_beats.size(), count));
        end
    endtask

    task automatic compare_reply(input int idx, input udp_pkg::udp_hdr_t sent);
        udp_pkg::udp_hdr_t exp;
        exp = expected_reply(sent);
        if (idx < got_hdrs.size()) begin
            check_value("tx_hdr.source_ip", got_hdrs[idx].source_ip, exp.source_ip);
            check_value("tx_hdr.dest_ip", got_hdrs[idx].dest_ip, exp.dest_ip);
            check_value("tx_hdr.source_port", got_hdrs[idx].source_port, exp.source_port);
            check_value("tx_hdr.dest_port", got_hdrs[idx].dest_port, exp.dest_port);
            check_value("tx_hdr.length", got_hdrs[idx].length, exp.length);
            check_value("tx_hdr.ttl", got_hdrs[idx].ttl, exp.ttl);
            check_value("tx_hdr.checksum", got_hdrs[idx].checksum, exp.checksum);
        end
    endtask

    task automatic compare_payload(input int offset, input beat_q_t sent);
        int j;
        for (j = 0; j < sent.size() && offset + j < got_beats.size(); j++) begin
            check_value($sformatf("tx_payload.data[%0d]", offset + j),
                        got_beats[offset + j].data, sent[j].data);
            check_value($sformatf("tx_payload.last[%0d]", offset + j),
                        got_beats[offset + j].last, sent[j].last);
            check_value($sformatf("tx_payload.user[%0d]", offset + j),
                        got_beats[offset + j].user, sent[j].user);
        end
    endtask

    // Readies stay high and nothing may come out
    task automatic expect_silence(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            tx_hdr_ready     = 1'b1;
            tx_payload_ready = 1'b1;
            if (tx_hdr_valid || tx_payload_valid) begin
                report_failure("output appeared for a datagram to another port");
            end
        end
        @(negedge clk);
        tx_hdr_ready     = 1'b0;
        tx_payload_ready = 1'b0;
    endtask

    task automatic echo_and_check(input int n, input int user_idx);
        udp_pkg::udp_hdr_t hdr;
        beat_q_t           beats;
        hdr   = make_header(udp_pkg::DEFAULT_LISTEN_PORT, n);
        beats = make_payload(n, user_idx);
        got_hdrs.delete();
        got_beats.delete();
        fork
            send_datagram(hdr, beats);
            collect_headers(1);
            collect_payload(n);
        join
        compare_reply(0, hdr);
        compare_payload(0, beats);
        check_value("leds", leds, beats[0].data);
    endtask

    task automatic discard_and_check(input int n);
        udp_pkg::udp_hdr_t hdr;
        logic [7:0]        leds_before;
        hdr         = make_header(OTHER_PORT, n);
        leds_before = leds;
        send_datagram(hdr, make_payload(n, -1));
        expect_silence(8);
        check_value("rx_payload_ready", rx_payload_ready, 1'b0);
        check_value("leds", leds, leds_before);
    endtask

    task automatic reset_test();
        int errors_before;
        errors_before = errors;
        check_value("tx_hdr_valid", tx_hdr_valid, 1'b0);
        check_value("tx_payload_valid", tx_payload_valid, 1'b0);
        check_value("rx_payload_ready", rx_payload_ready, 1'b0);
        check_value("rx_hdr_ready", rx_hdr_ready, 1'b1);
        check_value("leds", leds, 8'h00);
        end_test("reset", errors_before);
    endtask

    task automatic echo_test();
        int errors_before;
        errors_before = errors;
        echo_and_check(10, 3);
        end_test("echo", errors_before);
    endtask

    task automatic discard_test();
        int errors_before;
        errors_before = errors;
        discard_and_check(8);
        echo_and_check(6, -1);
        end_test("discard", errors_before);
    endtask

    task automatic backpressure_test();
        udp_pkg::udp_hdr_t hdrs[3];
        beat_q_t           sent[3];
        int                i;
        int                wait_cycles;
        int                errors_before;
        errors_before = errors;
        for (i = 0; i < 3; i++) begin
            hdrs[i] = make_header(udp_pkg::DEFAULT_LISTEN_PORT, 20);
            sent[i] = make_payload(20, i * 7);
        end
        got_hdrs.delete();
        got_beats.delete();
        payload_stalls = 0;
        wait_cycles    = 0;
        fork
            for (int k = 0; k < 3; k++) begin
                send_datagram(hdrs[k], sent[k]);
            end
            begin
                while (payload_stalls == 0 && wait_cycles < IDLE_LIMIT) begin
                    @(negedge clk);
                    wait_cycles++;
                end
                if (payload_stalls == 0) begin
                    report_failure("rx_payload_ready never fell with the tx side held");
                end
                check_value("tx_hdr_valid", tx_hdr_valid, 1'b1);
                fork
                    collect_headers(3);
                    collect_payload(60);
                join
            end
        join
        for (i = 0; i < 3; i++) begin
            compare_reply(i, hdrs[i]);
            compare_payload(i * 20, sent[i]);
        end
        check_value("leds", leds, sent[2][0].data);
        end_test("backpressure", errors_before);
    endtask

    task automatic led_test();
        int errors_before;
        errors_before = errors;
        echo_and_check(5, -1);
        discard_and_check(4);
        echo_and_check(3, 0);
        discard_and_check(2);
        end_test("leds", errors_before);
    endtask

    initial begin
        lfsr_state       = 16'd21121;
        checks           = 0;
        errors           = 0;
        payload_stalls   = 0;
        rst              = 1'b1;
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        rx_payload       = '0;
        rx_payload_valid = 1'b0;
        tx_hdr_ready     = 1'b0;
        tx_payload_ready = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        reset_test();
        echo_test();
        discard_test();
        backpressure_test();
        led_test();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* build.f */
logic/stream_pkg.sv
logic/udp_pkg.sv
logic/stream_fifo.sv
logic/datagram_filter.sv
logic/led_capture.sv
logic/udp_echo_top.sv
tb/tb_udp_echo.sv

/* Bender.yml */
package:
  name: udp_echo

sources:
  # Packages first, then the modules that use them
  - logic/stream_pkg.sv
  - logic/udp_pkg.sv
  - logic/stream_fifo.sv
  - logic/datagram_filter.sv
  - logic/led_capture.sv
  - logic/udp_echo_top.sv
  - target: test
    files:
      - tb/tb_udp_echo.sv
